// File: logic/periph_pkg.sv
`default_nettype none

package periph_pkg;

   // Core bus
   localparam int DATA_W = 32;
   localparam int BE_W = 4;
   localparam logic [DATA_W-1:0] BASE_ADDR = 32'h1000_0000;

   localparam int TIM_W = 64;

   // Timer registers
   localparam logic [DATA_W-1:0] OFS_TIM_CTRL = 32'h00;
   localparam logic [DATA_W-1:0] OFS_TIM_THRESH_L = 32'h04;
   localparam logic [DATA_W-1:0] OFS_TIM_THRESH_H = 32'h08;
   localparam logic [DATA_W-1:0] OFS_TIM_OUT_L = 32'h0C;
   localparam logic [DATA_W-1:0] OFS_TIM_OUT_H = 32'h10;

   // PWM registers with one divider and setpoint pair per channel
   localparam logic [DATA_W-1:0] OFS_PWM_EN = 32'h1C;
   localparam logic [DATA_W-1:0] OFS_PWM_DIV_0 = 32'h20;
   localparam logic [DATA_W-1:0] OFS_PWM_SET_0 = 32'h24;
   localparam int PWM_STRIDE = 8;

   // GPIO registers
   localparam logic [DATA_W-1:0] OFS_GPIO_SEL = 32'h40;
   localparam logic [DATA_W-1:0] OFS_GPIO_OUT = 32'h44;
   localparam logic [DATA_W-1:0] OFS_GPIO_IN = 32'h48;
   localparam logic [DATA_W-1:0] OFS_GPIO_OE = 32'h4C;

   // Timer control bits
   localparam int TIM_EN_BIT = 0;
   localparam int TIM_IRQ_BIT = 1;

   localparam int PWM_DIV_W = 8;

endpackage

`default_nettype wire

// File: logic/pin_pkg.sv
`default_nettype none

package pin_pkg;

   // Select field per pad
   localparam int SEL_W = 2;

   // Pad source codes
   localparam logic [SEL_W-1:0] SEL_GPIO = 2'd0;
   localparam logic [SEL_W-1:0] SEL_PWM = 2'd1;
   localparam logic [SEL_W-1:0] SEL_TIMER = 2'd2;

   // Parked pad, driven low
   localparam logic [SEL_W-1:0] SEL_LOW = 2'd3;

endpackage

`default_nettype wire

// File: logic/periph_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module periph_regfile #(
   parameter logic [periph_pkg::DATA_W-1:0] START_ADDR = periph_pkg::BASE_ADDR,
   parameter int NUM_PINS = 8,
   parameter int NUM_PWM = 2,
   parameter int MOD_WIDTH = 8
) (
   input  wire                                         i_clk,
   input  wire                                         i_reset,
   input  wire                                         i_req,
   input  wire                                         i_we,
   input  wire [periph_pkg::DATA_W-1:0]                i_addr,
   input  wire [periph_pkg::DATA_W-1:0]                i_wdata,
   input  wire [periph_pkg::BE_W-1:0]                  i_be,
   input  wire [periph_pkg::TIM_W-1:0]                 i_tim_count,
   input  wire                                         i_tim_irq,
   input  wire [NUM_PINS-1:0]                          i_gpio_in,
   output logic                                        o_gnt,
   output logic                                        o_rvalid,
   output logic [periph_pkg::DATA_W-1:0]               o_rdata,
   output logic                                        o_tim_en,
   output logic [periph_pkg::TIM_W-1:0]                o_tim_thresh,
   output logic                                        o_tim_clear,
   output logic [NUM_PWM-1:0]                          o_pwm_en,
   output logic [NUM_PWM*periph_pkg::PWM_DIV_W-1:0]    o_pwm_div,
   output logic [NUM_PWM*MOD_WIDTH-1:0]                o_pwm_set,
   output logic [NUM_PINS*pin_pkg::SEL_W-1:0]          o_gpio_sel,
   output logic [NUM_PINS-1:0]                         o_gpio_out,
   output logic [NUM_PINS-1:0]                         o_gpio_oe
);

   localparam int DW = periph_pkg::DATA_W;
   localparam int DIV_W = periph_pkg::PWM_DIV_W;
   localparam int SEL_BITS = NUM_PINS * pin_pkg::SEL_W;

   logic [DW-1:0] offs;
   logic          wr_en;
   logic          rd_en;
   logic [DW-1:0] rd_mux;

   // Lanes with a set strobe take the new byte
   function automatic logic [DW-1:0] be_merge(
      input logic [DW-1:0]                 old_val,
      input logic [DW-1:0]                 new_val,
      input logic [periph_pkg::BE_W-1:0]   be
   );
      logic [DW-1:0] res;
      res = old_val;
      for (int b = 0; b < periph_pkg::BE_W; b++) begin
         if (be[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus handshake
   ////////////////////////////////////////////////////////////

   assign offs = i_addr - START_ADDR;
   assign wr_en = i_req & i_we;
   assign rd_en = i_req & ~i_we;
   assign o_gnt = i_req;

   // Any write to the control word restarts the count
   assign o_tim_clear = wr_en && (offs == periph_pkg::OFS_TIM_CTRL);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_rvalid <= 1'b0;
      end else begin
         o_rvalid <= i_req;
      end
   end

   always_ff @(posedge i_clk) begin
      o_rdata <= rd_en ? rd_mux : '0;
   end

   ////////////////////////////////////////////////////////////
   // Register storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_tim_en <= 1'b0;
         o_tim_thresh <= '0;
         o_pwm_en <= '0;
         o_pwm_div <= '0;
         o_pwm_set <= '0;
         o_gpio_sel <= '0;
         o_gpio_out <= '0;
         o_gpio_oe <= '0;
      end else if (wr_en) begin
         case (offs)
            periph_pkg::OFS_TIM_CTRL: begin
               if (i_be[periph_pkg::TIM_EN_BIT / 8]) begin
                  o_tim_en <= i_wdata[periph_pkg::TIM_EN_BIT];
               end
            end
            periph_pkg::OFS_TIM_THRESH_L:
               o_tim_thresh[DW-1:0] <= be_merge(o_tim_thresh[DW-1:0], i_wdata, i_be);
            periph_pkg::OFS_TIM_THRESH_H:
               o_tim_thresh[2*DW-1:DW] <= be_merge(o_tim_thresh[2*DW-1:DW], i_wdata, i_be);
            periph_pkg::OFS_PWM_EN:
               o_pwm_en <= NUM_PWM'(be_merge(o_pwm_en, i_wdata, i_be));
            periph_pkg::OFS_GPIO_SEL:
               o_gpio_sel <= SEL_BITS'(be_merge(o_gpio_sel, i_wdata, i_be));
            periph_pkg::OFS_GPIO_OUT:
               o_gpio_out <= NUM_PINS'(be_merge(o_gpio_out, i_wdata, i_be));
            periph_pkg::OFS_GPIO_OE:
               o_gpio_oe <= NUM_PINS'(be_merge(o_gpio_oe, i_wdata, i_be));
            default: ;
         endcase
         for (int n = 0; n < NUM_PWM; n++) begin
            if (offs == periph_pkg::OFS_PWM_DIV_0 + periph_pkg::PWM_STRIDE * n) begin
               o_pwm_div[n*DIV_W +: DIV_W] <=
                  DIV_W'(be_merge(o_pwm_div[n*DIV_W +: DIV_W], i_wdata, i_be));
            end
            if (offs == periph_pkg::OFS_PWM_SET_0 + periph_pkg::PWM_STRIDE * n) begin
               o_pwm_set[n*MOD_WIDTH +: MOD_WIDTH] <=
                  MOD_WIDTH'(be_merge(o_pwm_set[n*MOD_WIDTH +: MOD_WIDTH], i_wdata, i_be));
            end
         end
      end
   end

   // Read-back mux with zero for holes in the map
   always_comb begin
      rd_mux = '0;
      case (offs)
         periph_pkg::OFS_TIM_CTRL: begin
            rd_mux[periph_pkg::TIM_EN_BIT] = o_tim_en;
            rd_mux[periph_pkg::TIM_IRQ_BIT] = i_tim_irq;
         end
         periph_pkg::OFS_TIM_THRESH_L: rd_mux = o_tim_thresh[DW-1:0];
         periph_pkg::OFS_TIM_THRESH_H: rd_mux = o_tim_thresh[2*DW-1:DW];
         periph_pkg::OFS_TIM_OUT_L:    rd_mux = i_tim_count[DW-1:0];
         periph_pkg::OFS_TIM_OUT_H:    rd_mux = i_tim_count[2*DW-1:DW];
         periph_pkg::OFS_PWM_EN:       rd_mux[NUM_PWM-1:0] = o_pwm_en;
         periph_pkg::OFS_GPIO_SEL:     rd_mux[SEL_BITS-1:0] = o_gpio_sel;
         periph_pkg::OFS_GPIO_OUT:     rd_mux[NUM_PINS-1:0] = o_gpio_out;
         periph_pkg::OFS_GPIO_IN:      rd_mux[NUM_PINS-1:0] = i_gpio_in;
         periph_pkg::OFS_GPIO_OE:      rd_mux[NUM_PINS-1:0] = o_gpio_oe;
         default: ;
      endcase
      for (int n = 0; n < NUM_PWM; n++) begin
         if (offs == periph_pkg::OFS_PWM_DIV_0 + periph_pkg::PWM_STRIDE * n) begin
            rd_mux[DIV_W-1:0] = o_pwm_div[n*DIV_W +: DIV_W];
         end
         if (offs == periph_pkg::OFS_PWM_SET_0 + periph_pkg::PWM_STRIDE * n) begin
            rd_mux[MOD_WIDTH-1:0] = o_pwm_set[n*MOD_WIDTH +: MOD_WIDTH];
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/periph_timer.sv
`timescale 1ns/10ps
`default_nettype none

module periph_timer (
   input  wire                           i_clk,
   input  wire                           i_reset,
   input  wire                           i_en,
   input  wire                           i_clear,
   input  wire [periph_pkg::TIM_W-1:0]   i_thresh,
   output logic [periph_pkg::TIM_W-1:0]  o_count,
   output logic                          o_irq
);

   ////////////////////////////////////////////////////////////
   // Free-running count
   ////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_count <= '0;
      end else if (i_clear) begin
         o_count <= '0;
      end else if (i_en) begin
         o_count <= o_count + 1'b1;
      end
   end

   // Compare on the current count, so irq trails it by one cycle
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_irq <= 1'b0;
      end else begin
         o_irq <= i_en && !i_clear && (o_count >= i_thresh);
      end
   end

endmodule

`default_nettype wire

// File: logic/pwm_modulator.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_modulator #(
   parameter int NUM_PWM = 2,
   parameter int MOD_WIDTH = 8
) (
   input  wire                                       i_clk,
   input  wire                                       i_reset,
   input  wire [NUM_PWM-1:0]                         i_en,
   input  wire [NUM_PWM*periph_pkg::PWM_DIV_W-1:0]   i_div,
   input  wire [NUM_PWM*MOD_WIDTH-1:0]               i_set,
   output logic [NUM_PWM-1:0]                        o_pwm
);

   localparam int DIV_W = periph_pkg::PWM_DIV_W;

   for (genvar n = 0; n < NUM_PWM; n++) begin : g_chan
      logic [DIV_W-1:0]     presc;
      logic [MOD_WIDTH-1:0] phase;

      // Phase steps once per div+1 cycles and wraps on its own width
      always_ff @(posedge i_clk) begin
         if (i_reset || !i_en[n]) begin
            presc <= '0;
            phase <= '0;
         end else if (presc >= i_div[n*DIV_W +: DIV_W]) begin
            presc <= '0;
            phase <= phase + 1'b1;
         end else begin
            presc <= presc + 1'b1;
         end
      end

      // Disabled channel sits low
      assign o_pwm[n] = i_en[n] && (phase < i_set[n*MOD_WIDTH +: MOD_WIDTH]);
   end

endmodule

`default_nettype wire

// File: logic/pin_mux.sv
`timescale 1ns/10ps
`default_nettype none

module pin_mux #(
   parameter int NUM_PINS = 8,
   parameter int NUM_PWM = 2
) (
   input  wire                                  i_clk,
   input  wire                                  i_reset,
   input  wire [NUM_PINS*pin_pkg::SEL_W-1:0]    i_sel,
   input  wire [NUM_PINS-1:0]                   i_gpio_out,
   input  wire [NUM_PINS-1:0]                   i_gpio_oe,
   input  wire [NUM_PWM-1:0]                    i_pwm,
   input  wire                                  i_timer_irq,
   input  wire [NUM_PINS-1:0]                   i_io_in,
   output logic [NUM_PINS-1:0]                  o_gpio_in,
   output logic [NUM_PINS-1:0]                  o_io_out,
   output logic [NUM_PINS-1:0]                  o_io_oeb_n
);

   localparam int SEL_W = pin_pkg::SEL_W;

   logic [NUM_PINS-1:0] pad_oe;

   // Pad source per select code
   always_comb begin
      for (int p = 0; p < NUM_PINS; p++) begin
         pad_oe[p] = 1'b1;
         case (i_sel[p*SEL_W +: SEL_W])
            pin_pkg::SEL_GPIO: begin
               o_io_out[p] = i_gpio_out[p];
               pad_oe[p] = i_gpio_oe[p];
            end
            pin_pkg::SEL_PWM:   o_io_out[p] = i_pwm[p % NUM_PWM];
            pin_pkg::SEL_TIMER: o_io_out[p] = i_timer_irq;
            default:            o_io_out[p] = 1'b0;
         endcase
      end
   end

   assign o_io_oeb_n = ~pad_oe;

   // Pad sampling for the GPIO input register
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_gpio_in <= '0;
      end else begin
         o_gpio_in <= i_io_in;
      end
   end

endmodule

`default_nettype wire

// File: logic/peripheral_unit.sv
`timescale 1ns/10ps
`default_nettype none

module peripheral_unit #(
   parameter logic [periph_pkg::DATA_W-1:0] START_ADDR = periph_pkg::BASE_ADDR,
   parameter int NUM_PINS = 8,
   parameter int NUM_PWM = 2,
   parameter int MOD_WIDTH = 8
) (
   input  wire                            i_clk,
   input  wire                            i_reset,
   input  wire                            i_req,
   input  wire                            i_we,
   input  wire [periph_pkg::DATA_W-1:0]   i_addr,
   input  wire [periph_pkg::DATA_W-1:0]   i_wdata,
   input  wire [periph_pkg::BE_W-1:0]     i_be,
   input  wire [NUM_PINS-1:0]             i_io_in,
   output logic                           o_gnt,
   output logic                           o_rvalid,
   output logic [periph_pkg::DATA_W-1:0]  o_rdata,
   output logic                           o_timer_intr,
   output logic [NUM_PINS-1:0]            o_io_out,
   output logic [NUM_PINS-1:0]            o_io_oeb_n
);

   logic                                      tim_en;
   logic [periph_pkg::TIM_W-1:0]              tim_thresh;
   logic                                      tim_clear;
   logic [periph_pkg::TIM_W-1:0]              tim_count;
   logic [NUM_PWM-1:0]                        pwm_en;
   logic [NUM_PWM*periph_pkg::PWM_DIV_W-1:0]  pwm_div;
   logic [NUM_PWM*MOD_WIDTH-1:0]              pwm_set;
   logic [NUM_PWM-1:0]                        pwm_out;
   logic [NUM_PINS*pin_pkg::SEL_W-1:0]        gpio_sel;
   logic [NUM_PINS-1:0]                       gpio_out;
   logic [NUM_PINS-1:0]                       gpio_oe;
   logic [NUM_PINS-1:0]                       gpio_in;

   ////////////////////////////////////////////////////////////
   // Register file on the core bus
   ////////////////////////////////////////////////////////////

   periph_regfile #(
      .START_ADDR (START_ADDR),
      .NUM_PINS   (NUM_PINS),
      .NUM_PWM    (NUM_PWM),
      .MOD_WIDTH  (MOD_WIDTH)
   ) regfile_i (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_req        (i_req),
      .i_we         (i_we),
      .i_addr       (i_addr),
      .i_wdata      (i_wdata),
      .i_be         (i_be),
      .i_tim_count  (tim_count),
      .i_tim_irq    (o_timer_intr),
      .i_gpio_in    (gpio_in),
      .o_gnt        (o_gnt),
      .o_rvalid     (o_rvalid),
      .o_rdata      (o_rdata),
      .o_tim_en     (tim_en),
      .o_tim_thresh (tim_thresh),
      .o_tim_clear  (tim_clear),
      .o_pwm_en     (pwm_en),
      .o_pwm_div    (pwm_div),
      .o_pwm_set    (pwm_set),
      .o_gpio_sel   (gpio_sel),
      .o_gpio_out   (gpio_out),
      .o_gpio_oe    (gpio_oe)
   );

   ////////////////////////////////////////////////////////////
   // Timer and PWM side by side feeding the pad mux
   ////////////////////////////////////////////////////////////

   periph_timer timer_i (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_en     (tim_en),
      .i_clear  (tim_clear),
      .i_thresh (tim_thresh),
      .o_count  (tim_count),
      .o_irq    (o_timer_intr)
   );

   pwm_modulator #(
      .NUM_PWM   (NUM_PWM),
      .MOD_WIDTH (MOD_WIDTH)
   ) pwm_i (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_en    (pwm_en),
      .i_div   (pwm_div),
      .i_set   (pwm_set),
      .o_pwm   (pwm_out)
   );

   pin_mux #(
      .NUM_PINS (NUM_PINS),
      .NUM_PWM  (NUM_PWM)
   ) pin_mux_i (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_sel       (gpio_sel),
      .i_gpio_out  (gpio_out),
      .i_gpio_oe   (gpio_oe),
      .i_pwm       (pwm_out),
      .i_timer_irq (o_timer_intr),
      .i_io_in     (i_io_in),
      .o_gpio_in   (gpio_in),
      .o_io_out    (o_io_out),
      .o_io_oeb_n  (o_io_oeb_n)
   );

endmodule

`default_nettype wire

// File: tb/peripheral_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module peripheral_unit_tb;

   localparam int NUM_PINS = 8;
   localparam int DW = periph_pkg::DATA_W;
   localparam int WAIT_LIMIT = 1000;

   logic                  i_clk;
   logic                  i_reset;
   logic                  i_req;
   logic                  i_we;
   logic [DW-1:0]         i_addr;
   logic [DW-1:0]         i_wdata;
   logic [periph_pkg::BE_W-1:0] i_be;
   logic [NUM_PINS-1:0]   i_io_in;
   wire                   o_gnt;
   wire                   o_rvalid;
   wire [DW-1:0]          o_rdata;
   wire                   o_timer_intr;
   wire [NUM_PINS-1:0]    o_io_out;
   wire [NUM_PINS-1:0]    o_io_oeb_n;

   int     value_errors = 0;
   int     other_errors = 0;
   integer seed = 32'h341e_3ad0;

   peripheral_unit #(
      .START_ADDR (periph_pkg::BASE_ADDR),
      .NUM_PINS   (NUM_PINS),
      .NUM_PWM    (2),
      .MOD_WIDTH  (8)
   ) peripheral_unit_i (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_req        (i_req),
      .i_we         (i_we),
      .i_addr       (i_addr),
      .i_wdata      (i_wdata),
      .i_be         (i_be),
      .i_io_in      (i_io_in),
      .o_gnt        (o_gnt),
      .o_rvalid     (o_rvalid),
      .o_rdata      (o_rdata),
      .o_timer_intr (o_timer_intr),
      .o_io_out     (o_io_out),
      .o_io_oeb_n   (o_io_oeb_n)
   );

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   task automatic report_mismatch(input string name, input logic [DW-1:0] exp,
                                  input logic [DW-1:0] got);
      value_errors++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
   endtask

   task automatic report_failure(input string msg);
      other_errors++;
      $display("Failure at %0t ns: %s", $time, msg);
   endtask

   ////////////////////////////////////////////////////////////
   // Bus access as one request and an idle cycle after it
   ////////////////////////////////////////////////////////////

   task automatic bus_access(input logic we, input logic [DW-1:0] offs,
                             input logic [DW-1:0] wdata, input logic [3:0] be,
                             output logic [DW-1:0] rdata);
      int n;
      @(posedge i_clk);
      i_req <= 1'b1;
      i_we <= we;
      i_addr <= periph_pkg::BASE_ADDR + offs;
      i_wdata <= wdata;
      i_be <= be;
      @(negedge i_clk);
      if (o_gnt !== 1'b1) report_mismatch("o_gnt", 1, o_gnt);
      @(posedge i_clk);
      i_req <= 1'b0;
      i_we <= 1'b0;
      n = 0;
      do begin
         @(negedge i_clk);
         n++;
      end while (o_rvalid !== 1'b1 && n < WAIT_LIMIT);
      if (o_rvalid !== 1'b1) begin
         report_failure("timed out waiting for o_rvalid");
      end else if (n != 1) begin
         report_failure($sformatf("o_rvalid came %0d cycles after the grant", n));
      end
      rdata = o_rdata;
      // Read-valid lasts a single cycle
      @(negedge i_clk);
      if (o_rvalid !== 1'b0) report_mismatch("o_rvalid", 0, o_rvalid);
   endtask

   task automatic wait_pad(input int pin, input logic level);
      int n;
      n = 0;
      while (o_io_out[pin] !== level && n < WAIT_LIMIT) begin
         @(negedge i_clk);
         n++;
      end
      if (o_io_out[pin] !== level) begin
         report_failure($sformatf("timed out waiting for pad %0d to go %0b", pin, level));
      end
   endtask

   task automatic wait_intr(input logic level);
      int n;
      n = 0;
      while (o_timer_intr !== level && n < WAIT_LIMIT) begin
         @(negedge i_clk);
         n++;
      end
      if (o_timer_intr !== level) begin
         report_failure($sformatf("timed out waiting for o_timer_intr to go %0b", level));
      end
   endtask

   // One bus operation per line and # for comment lines
   task automatic replay_vectors();
      integer           fd;
      integer           cnt;
      int               done;
      logic [8*100-1:0] line;
      logic [8*8-1:0]   op;
      logic [DW-1:0]    offs;
      logic [DW-1:0]    wdata;
      logic [DW-1:0]    exp_rd;
      logic [DW-1:0]    rdata;
      logic [3:0]       be;
      done = 0;
      fd = $fopen("tb/peripheral_vectors.txt", "r");
      if (fd == 0) begin
         report_failure("could not open tb/peripheral_vectors.txt");
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            cnt = $fgets(line, fd);
            cnt = (cnt > 0) ? $sscanf(line, "%s %h %h %h %h", op, offs, wdata, be, exp_rd) : 0;
            if (cnt == 5 && op != "#") begin
               if (op != "W" && op != "R") begin
                  report_failure("vector line with an unknown operation");
               end
               bus_access(op == "W", offs, wdata, be, rdata);
               if (rdata !== exp_rd) report_mismatch("o_rdata", exp_rd, rdata);
               done++;
            end
         end
         $fclose(fd);
         if (done == 0) report_failure("no bus operations in the vector file");
      end
   endtask

   initial begin
      logic [DW-1:0] rdata;
      logic [DW-1:0] first;
      int            high_cnt;
      i_reset = 1'b1;
      i_req = 1'b0;
      i_we = 1'b0;
      i_addr = '0;
      i_wdata = '0;
      i_be = '0;
      i_io_in = '0;
      repeat (4) @(posedge i_clk);
      i_reset <= 1'b0;
      @(negedge i_clk);
      if (o_gnt !== 1'b0) report_mismatch("o_gnt", 0, o_gnt);
      if (o_rvalid !== 1'b0) report_mismatch("o_rvalid", 0, o_rvalid);
      if (o_timer_intr !== 1'b0) report_mismatch("o_timer_intr", 0, o_timer_intr);
      if (o_io_oeb_n !== 8'hff) report_mismatch("o_io_oeb_n", 8'hff, o_io_oeb_n);

      replay_vectors();

      ////////////////////////////////////////////////////////////
      // GPIO pads
      ////////////////////////////////////////////////////////////
      bus_access(1'b1, periph_pkg::OFS_GPIO_SEL, 32'h0, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_GPIO_OUT, 32'h96, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_GPIO_OE, 32'h0f, 4'hf, rdata);
      if (o_io_out !== 8'h96) report_mismatch("o_io_out", 8'h96, o_io_out);
      if (o_io_oeb_n !== 8'hf0) report_mismatch("o_io_oeb_n", 8'hf0, o_io_oeb_n);
      for (int k = 0; k < 2; k++) begin
         @(posedge i_clk);
         i_io_in <= k ? 8'ha4 : 8'h5b;
         bus_access(1'b0, periph_pkg::OFS_GPIO_IN, 32'h0, 4'hf, rdata);
         if (rdata !== (k ? 32'ha4 : 32'h5b)) begin
            report_mismatch("o_rdata", k ? 32'ha4 : 32'h5b, rdata);
         end
      end
      // Pin 7 parked low and driven
      bus_access(1'b1, periph_pkg::OFS_GPIO_SEL, 32'hc000, 4'hf, rdata);
      if (o_io_out !== 8'h16) report_mismatch("o_io_out", 8'h16, o_io_out);
      if (o_io_oeb_n !== 8'h70) report_mismatch("o_io_oeb_n", 8'h70, o_io_oeb_n);

      ////////////////////////////////////////////////////////////
      // PWM duty on pin 0
      ////////////////////////////////////////////////////////////
      bus_access(1'b1, periph_pkg::OFS_PWM_DIV_0, 32'd1, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_PWM_SET_0, 32'd64, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_GPIO_SEL, 32'h1, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_PWM_EN, 32'h1, 4'hf, rdata);
      if (o_io_oeb_n[0] !== 1'b0) report_mismatch("o_io_oeb_n[0]", 0, o_io_oeb_n[0]);
      wait_pad(0, 1'b0);
      wait_pad(0, 1'b1);
      // 256 phases of 2 cycles each with the pad high while phase < 64
      high_cnt = o_io_out[0];
      repeat (511) begin
         @(negedge i_clk);
         high_cnt += o_io_out[0];
      end
      if (high_cnt != 128) report_mismatch("pwm high cycles", 128, high_cnt);
      bus_access(1'b1, periph_pkg::OFS_PWM_EN, 32'h0, 4'hf, rdata);
      repeat (16) begin
         repeat ($unsigned($random(seed)) % 8 + 1) @(negedge i_clk);
         if (o_io_out[0] !== 1'b0) report_mismatch("o_io_out[0]", 0, o_io_out[0]);
      end

      ////////////////////////////////////////////////////////////
      // Timer
      ////////////////////////////////////////////////////////////
      bus_access(1'b1, periph_pkg::OFS_TIM_THRESH_L, 32'd40, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_TIM_THRESH_H, 32'd0, 4'hf, rdata);
      bus_access(1'b1, periph_pkg::OFS_TIM_CTRL, 32'h1, 4'hf, rdata);
      bus_access(1'b0, periph_pkg::OFS_TIM_OUT_L, 32'h0, 4'hf, first);
      bus_access(1'b0, periph_pkg::OFS_TIM_OUT_L, 32'h0, 4'hf, rdata);
      if (rdata <= first) begin
         value_errors++;
         $display("[ERROR] %0t ns: TIM_OUT_L expected above %h, got %h", $time, first, rdata);
      end
      wait_intr(1'b1);
      // Timer interrupt on pin 3
      bus_access(1'b1, periph_pkg::OFS_GPIO_SEL, 32'h80, 4'hf, rdata);
      if (o_io_out[3] !== 1'b1) report_mismatch("o_io_out[3]", 1, o_io_out[3]);
      if (o_io_oeb_n[3] !== 1'b0) report_mismatch("o_io_oeb_n[3]", 0, o_io_oeb_n[3]);
      bus_access(1'b0, periph_pkg::OFS_TIM_CTRL, 32'h0, 4'hf, rdata);
      if (rdata !== 32'h3) report_mismatch("o_rdata", 32'h3, rdata);
      bus_access(1'b1, periph_pkg::OFS_TIM_CTRL, 32'h1, 4'hf, rdata);
      wait_intr(1'b0);
      if (o_io_out[3] !== 1'b0) report_mismatch("o_io_out[3]", 0, o_io_out[3]);
      bus_access(1'b0, periph_pkg::OFS_TIM_OUT_L, 32'h0, 4'hf, rdata);
      if (rdata >= 32'd40) begin
         value_errors++;
         $display("[ERROR] %0t ns: TIM_OUT_L expected below %h, got %h", $time, 32'd40, rdata);
      end

      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/peripheral_vectors.txt
# op offset wdata be expected_rdata, all fields hex
# op W writes, R reads, offset relative to the block base
W 44 000000a5 f 00000000
R 44 00000000 f 000000a5
W 44 0000005a e 00000000
R 44 00000000 f 000000a5
W 4c 0000003c 1 00000000
R 4c 00000000 f 0000003c
W 40 0000b7e4 f 00000000
W 40 00001200 2 00000000
R 40 00000000 f 000012e4
W 04 11223344 f 00000000
W 04 aabbccdd 5 00000000
R 04 00000000 f 11bb33dd
W 20 00000003 f 00000000
R 20 00000000 f 00000003
W 2c 000000c0 f 00000000
R 2c 00000000 f 000000c0
W 1c 00000003 f 00000000
W 1c 00000000 e 00000000
R 1c 00000000 f 00000003
W 1c 00000000 f 00000000
# unmapped offsets
R 14 00000000 f 00000000
R 30 00000000 f 00000000
R 50 00000000 f 00000000
W 38 ffffffff f 00000000
W 48 ffffffff f 00000000
R 44 00000000 f 000000a5
R 40 00000000 f 000012e4
R 48 00000000 f 00000000

// File: vlog.f
logic/periph_pkg.sv
logic/pin_pkg.sv
logic/periph_regfile.sv
logic/periph_timer.sv
logic/pwm_modulator.sv
logic/pin_mux.sv
logic/peripheral_unit.sv
tb/peripheral_unit_tb.sv
